// File: common/bus_pkg.sv
package bus_pkg;

	localparam int BUS_ADDR_W = 4;
	localparam int BUS_DATA_W = 32;
	localparam int BUS_STRB_W = BUS_DATA_W / 8;

	// transaction kind carried with each request
	typedef enum logic [0:0]
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	// one request, held stable by the master while req is high
	typedef struct packed
	{
		bus_op_e                 op;
		logic [BUS_ADDR_W-1:0]   addr;    // byte address
		logic [BUS_DATA_W-1:0]   wdata;
		logic [BUS_STRB_W-1:0]   wmask;   // bit n enables lane n
	} bus_req_t;

	// response, valid while ack is high
	typedef struct packed
	{
		logic [BUS_DATA_W-1:0]   rdata;
	} bus_rsp_t;

endpackage

// File: common/clint_pkg.sv
package clint_pkg;

	localparam int CLINT_ADDR_W = 4;
	localparam int REG_W        = 64;   // mtime and mtimecmp width

	// register window, 16 bytes
	localparam logic [CLINT_ADDR_W-1:0] MTIME_BASE    = 4'd0;
	localparam logic [CLINT_ADDR_W-1:0] MTIMECMP_BASE = 4'd8;

	// bus bridge FSM
	typedef enum logic [1:0]
	{
		ST_IDLE   = 2'd0,   // waiting for req
		ST_ACCESS = 2'd1,   // strobe cycle
		ST_ACK    = 2'd2    // ack held until req falls
	} bridge_state_e;

endpackage

// File: clint/clint_bus_bridge.sv
`timescale 1ns/1ps

module clint_bus_bridge (
	input  logic                              clk_i,
	input  logic                              reset_i,
	input  logic                              req_i,
	input  bus_pkg::bus_req_t                 bus_req_i,
	output logic                              ack_o,
	output bus_pkg::bus_rsp_t                 bus_rsp_o,
	output logic                              reg_csb_o,
	output logic                              reg_wen_o,
	output logic [bus_pkg::BUS_ADDR_W-1:0]    reg_addr_o,
	output logic [bus_pkg::BUS_DATA_W-1:0]    reg_wdata_o,
	output logic [bus_pkg::BUS_STRB_W-1:0]    reg_wmask_o,
	input  logic [bus_pkg::BUS_DATA_W-1:0]    reg_rdata_i
);

	import bus_pkg::*;
	import clint_pkg::*;

	bridge_state_e state_q;
	bridge_state_e state_d;
	bus_req_t      req_q;
	bus_rsp_t      rsp_q;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
				if (req_i)
					state_d = ST_ACCESS;
			ST_ACCESS:
				state_d = ST_ACK;   // single strobe per handshake
			ST_ACK:
				if (!req_i)
					state_d = ST_IDLE;
			default:
				state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			state_q <= ST_IDLE;
			rsp_q   <= '0;
		end
		else
		begin
			state_q <= state_d;
			if (state_q == ST_ACCESS)
				rsp_q.rdata <= reg_rdata_i;   // pre-write data on a write
		end
	end

	// request is captured once, on the edge that first sees req high
	always_ff @(posedge clk_i)
	begin
		if (state_q == ST_IDLE && req_i)
			req_q <= bus_req_i;
	end

	assign ack_o       = (state_q == ST_ACK);
	assign bus_rsp_o   = rsp_q;
	assign reg_csb_o   = (state_q != ST_ACCESS);
	assign reg_wen_o   = (req_q.op != OP_WRITE);
	assign reg_addr_o  = req_q.addr;
	assign reg_wdata_o = req_q.wdata;
	assign reg_wmask_o = req_q.wmask;

	property p_strobe_single;
		@(posedge clk_i) disable iff (!reset_i)
		!reg_csb_o |=> reg_csb_o;
	endproperty

	property p_ack_needs_req;
		@(posedge clk_i) disable iff (!reset_i)
		$rose(ack_o) |-> $past(req_i);
	endproperty

	a_strobe_single: assert property (p_strobe_single)
		else $error("register strobe low for two cycles");
	a_ack_needs_req: assert property (p_ack_needs_req)
		else $error("ack raised without a pending request");

endmodule

// File: clint/mtime_registers.sv
`timescale 1ns/1ps

module mtime_registers (
	input  logic                                clk_i,
	input  logic                                reset_i,
	input  logic                                csb_i,
	input  logic                                wen_i,
	input  logic [clint_pkg::CLINT_ADDR_W-1:0]  addr_i,
	input  logic [31:0]                         data_i,
	input  logic [3:0]                          wmask_i,
	output logic                                mtip_o,
	output logic [31:0]                         data_o
);

	import clint_pkg::*;

	logic [REG_W-1:0]        mtime_q;
	logic [REG_W-1:0]        mtimecmp_q;
	logic [CLINT_ADDR_W-1:0] lane_addr [4];
	logic [2:0]              lane_off [4];   // byte offset inside the selected register
	logic [3:0]              lane_cmp;
	logic [3:0]              wr_time;
	logic [3:0]              wr_cmp;
	logic                    write_en;
	logic                    hi_eq;
	logic                    hi_lt;
	logic                    lo_lt;

	assign write_en = !csb_i && !wen_i;

	// lane n sits at addr_i + n, wrapping inside the 16-byte window
	always_comb
	begin
		for (int n = 0; n < 4; n++)
		begin
			lane_addr[n] = addr_i + CLINT_ADDR_W'(n);
			lane_cmp[n]  = (lane_addr[n] >= MTIMECMP_BASE);
			lane_off[n]  = lane_addr[n][2:0];
			wr_time[n] = write_en && wmask_i[n] && !lane_cmp[n];
			wr_cmp[n]  = write_en && wmask_i[n] && lane_cmp[n];
		end
	end

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			mtime_q <= '0;
		else if (|wr_time)
		begin
			// written bytes load, the rest hold for this edge
			for (int n = 0; n < 4; n++)
			begin
				if (wr_time[n])
					mtime_q[8*lane_off[n][2:0] +: 8] <= data_i[8*n +: 8];
			end
		end
		else
			mtime_q <= mtime_q + 64'd1;
	end

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			mtimecmp_q <= '0;
		else
		begin
			for (int n = 0; n < 4; n++)
			begin
				if (wr_cmp[n])
					mtimecmp_q[8*lane_off[n][2:0] +: 8] <= data_i[8*n +: 8];
			end
		end
	end

	always_comb
	begin
		for (int n = 0; n < 4; n++)
		begin
			if (lane_cmp[n])
				data_o[8*n +: 8] = mtimecmp_q[8*lane_off[n][2:0] +: 8];
			else
				data_o[8*n +: 8] = mtime_q[8*lane_off[n][2:0] +: 8];
		end
	end

	// two 32-bit compares instead of one 64-bit one
	assign hi_eq  = (mtime_q[63:32] == mtimecmp_q[63:32]);
	assign hi_lt  = (mtime_q[63:32] <  mtimecmp_q[63:32]);
	assign lo_lt  = (mtime_q[31:0]  <  mtimecmp_q[31:0]);
	assign mtip_o = !(hi_lt || (hi_eq && lo_lt));

	property p_mtip_matches;
		@(posedge clk_i) disable iff (!reset_i)
		mtip_o == (mtime_q >= mtimecmp_q);
	endproperty

	a_mtip_matches: assert property (p_mtip_matches)
		else $error("mtip disagrees with 64-bit compare");

endmodule

// File: verilog/clint_timer_top.sv
`timescale 1ns/1ps

module clint_timer_top (
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              req_i,
	input  bus_pkg::bus_req_t bus_req_i,
	output logic              ack_o,
	output bus_pkg::bus_rsp_t bus_rsp_o,
	output logic              mtip_o
);

	import bus_pkg::*;

	logic                  reg_csb;
	logic                  reg_wen;
	logic [BUS_ADDR_W-1:0] reg_addr;
	logic [BUS_DATA_W-1:0] reg_wdata;
	logic [BUS_STRB_W-1:0] reg_wmask;
	logic [BUS_DATA_W-1:0] reg_rdata;

	clint_bus_bridge u_bridge (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.req_i       (req_i),
		.bus_req_i   (bus_req_i),
		.ack_o       (ack_o),
		.bus_rsp_o   (bus_rsp_o),
		.reg_csb_o   (reg_csb),
		.reg_wen_o   (reg_wen),
		.reg_addr_o  (reg_addr),
		.reg_wdata_o (reg_wdata),
		.reg_wmask_o (reg_wmask),
		.reg_rdata_i (reg_rdata)
	);

	mtime_registers u_mtime (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.csb_i   (reg_csb),
		.wen_i   (reg_wen),
		.addr_i  (reg_addr),
		.data_i  (reg_wdata),
		.wmask_i (reg_wmask),
		.mtip_o  (mtip_o),
		.data_o  (reg_rdata)
	);

endmodule

// File: tests/clint_timer_tb.sv
`timescale 1ns/1ps

module clint_timer_tb;

	import bus_pkg::*;
	import clint_pkg::*;

	logic        clk_i;
	logic        reset_i;
	logic        req_i;
	bus_req_t    bus_req_i;
	logic        ack_o;
	bus_rsp_t    bus_rsp_o;
	logic        mtip_o;

	logic [7:0]  cmp_model [8];   // expected mtimecmp bytes
	integer      seed;
	int          cycles;          // rising edges since reset release
	int          errors;
	int          err_mark;
	int          tests_run;
	int          c0;
	logic [31:0] rnd;
	bus_rsp_t    lo;
	bus_rsp_t    hi;
	bus_rsp_t    rd;
	bus_rsp_t    rsp;
	bus_rsp_t    exp_rsp;

	clint_timer_top uut (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.req_i     (req_i),
		.bus_req_i (bus_req_i),
		.ack_o     (ack_o),
		.bus_rsp_o (bus_rsp_o),
		.mtip_o    (mtip_o)
	);

	always #5 clk_i = ~clk_i;

	always @(posedge clk_i)
	begin
		if (reset_i)
			cycles <= cycles + 1;
	end

	// masked write of the model, lanes wrap inside 16 bytes
	function automatic void ref_write(logic [3:0] addr, logic [31:0] wdata, logic [3:0] wmask);
		logic [3:0] a;
		for (int n = 0; n < 4; n++)
		begin
			a = addr + 4'(n);
			if (wmask[n] && a[3])   // mtime lanes are not modeled
				cmp_model[a[2:0]] = wdata[8*n +: 8];
		end
	endfunction

	function automatic logic [31:0] ref_read_cmp(logic [3:0] addr);
		logic [3:0]  a;
		logic [31:0] r;
		for (int n = 0; n < 4; n++)
		begin
			a = addr + 4'(n);
			r[8*n +: 8] = cmp_model[a[2:0]];
		end
		return r;
	endfunction

	task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0d ns: %s, got %h expected %h", $time, what, got.rdata, exp.rdata);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %0d ns: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_range(input logic [63:0] got, input logic [63:0] low,
		input logic [63:0] high, input string what);
		if ($isunknown(got) || got < low || got > high)
		begin
			errors++;
			$display("FAIL %0d ns: %s, got %h expected %h..%h", $time, what, got, low, high);
		end
	endtask

	// one four-phase transaction, req optionally held after ack
	task automatic bus_access(input bus_op_e op, input logic [3:0] addr, input logic [31:0] wdata,
		input logic [3:0] wmask, input int hold, output bus_rsp_t r);
		@(negedge clk_i);
		bus_req_i = '{op: op, addr: addr, wdata: wdata, wmask: wmask};
		req_i     = 1'b1;
		while (!ack_o)
			@(negedge clk_i);
		r = bus_rsp_o;
		repeat (hold)
		begin
			@(negedge clk_i);
			check_bit(ack_o, 1'b1, "ack while req held");
			check_rsp(bus_rsp_o, r, "response while req held");
		end
		req_i = 1'b0;
		while (ack_o)
			@(negedge clk_i);
	endtask

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data, input logic [3:0] mask);
		bus_rsp_t r;
		bus_access(OP_WRITE, addr, data, mask, 0, r);
		ref_write(addr, data, mask);
	endtask

	task automatic read_reg(input logic [3:0] addr, output bus_rsp_t r);
		bus_access(OP_READ, addr, 32'd0, 4'd0, 0, r);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_mark)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	initial
	begin
		repeat (2000) @(posedge clk_i);
		$display("watchdog: simulation did not finish within 2000 clock cycles");
		$display("tests failed");
		$finish;
	end

	initial
	begin
		clk_i     = 1'b0;
		reset_i   = 1'b0;
		req_i     = 1'b0;
		bus_req_i = '0;
		seed      = 32'h9623;
		cycles    = 0;
		errors    = 0;
		err_mark  = 0;
		tests_run = 0;
		for (int i = 0; i < 8; i++)
			cmp_model[i] = 8'h00;
		repeat (8) @(posedge clk_i);
		@(negedge clk_i);
		reset_i = 1'b1;

		exp_rsp.rdata = 32'd0;
		check_bit(ack_o, 1'b0, "ack after reset");
		check_bit(mtip_o, 1'b1, "mtip after reset");
		check_rsp(bus_rsp_o, exp_rsp, "response after reset");
		read_reg(MTIMECMP_BASE, rd);
		check_rsp(rd, exp_rsp, "mtimecmp low word after reset");
		read_reg(MTIMECMP_BASE + 4'd4, rd);
		check_rsp(rd, exp_rsp, "mtimecmp high word after reset");
		end_test("reset state");

		// runs before any write can disturb mtime
		c0 = cycles;
		read_reg(MTIME_BASE, lo);
		check_range({32'd0, lo.rdata}, 64'd0, 64'(cycles), "first mtime read");
		repeat (50) @(negedge clk_i);
		read_reg(MTIME_BASE, hi);
		check_range({32'd0, hi.rdata}, 64'd0, 64'(cycles), "second mtime read");
		check_range(64'(hi.rdata - lo.rdata), 64'd50, 64'(cycles - c0), "mtime advance");
		end_test("mtime counting");

		for (int i = 0; i < 20; i++)
		begin
			rnd = $random(seed);
			write_reg(MTIMECMP_BASE + {1'b0, rnd[2:0]}, $random(seed), rnd[7:4]);
			read_reg(MTIMECMP_BASE, rd);
			exp_rsp.rdata = ref_read_cmp(MTIMECMP_BASE);
			check_rsp(rd, exp_rsp, "mtimecmp low word after masked write");
			read_reg(MTIMECMP_BASE + 4'd4, rd);
			exp_rsp.rdata = ref_read_cmp(MTIMECMP_BASE + 4'd4);
			check_rsp(rd, exp_rsp, "mtimecmp high word after masked write");
		end
		end_test("mtimecmp byte lanes");

		c0 = cycles;
		write_reg(MTIME_BASE, 32'hffff_fff0, 4'hf);
		write_reg(MTIME_BASE + 4'd4, 32'h0000_0001, 4'hf);
		read_reg(MTIME_BASE, lo);
		read_reg(MTIME_BASE + 4'd4, hi);
		check_range({hi.rdata, lo.rdata}, 64'h1_ffff_fff0,
			64'h1_ffff_fff0 + 64'(cycles - c0), "mtime after write");
		repeat (20) @(negedge clk_i);
		read_reg(MTIME_BASE + 4'd4, hi);   // high first, carry is already done
		read_reg(MTIME_BASE, lo);
		check_range({32'd0, hi.rdata}, 64'd2, 64'd2, "mtime high word after carry");
		check_range({hi.rdata, lo.rdata}, 64'h1_ffff_fff0,
			64'h1_ffff_fff0 + 64'(cycles - c0), "mtime after carry");
		end_test("mtime write");

		write_reg(MTIMECMP_BASE + 4'd4, 32'hffff_0000, 4'hf);
		check_bit(mtip_o, 1'b0, "mtip with mtimecmp far ahead");
		write_reg(MTIMECMP_BASE + 4'd4, 32'h0000_0000, 4'hf);
		check_bit(mtip_o, 1'b1, "mtip with mtimecmp behind");
		read_reg(MTIME_BASE, lo);
		read_reg(MTIME_BASE + 4'd4, hi);
		write_reg(MTIMECMP_BASE, lo.rdata + 32'd200, 4'hf);
		write_reg(MTIMECMP_BASE + 4'd4, hi.rdata, 4'hf);
		check_bit(mtip_o, 1'b0, "mtip right after deadline set");
		repeat (400) @(negedge clk_i);
		check_bit(mtip_o, 1'b1, "mtip after deadline passed");
		end_test("interrupt compare");

		// a second access would capture the new data as rdata
		exp_rsp.rdata = ref_read_cmp(MTIMECMP_BASE);
		bus_access(OP_WRITE, MTIMECMP_BASE, ~exp_rsp.rdata, 4'hf, 10, rsp);
		ref_write(MTIMECMP_BASE, ~exp_rsp.rdata, 4'hf);
		check_rsp(rsp, exp_rsp, "pre-write data under back-pressure");
		check_bit(ack_o, 1'b0, "ack after req released");
		read_reg(MTIMECMP_BASE, rd);
		exp_rsp.rdata = ref_read_cmp(MTIMECMP_BASE);
		check_rsp(rd, exp_rsp, "mtimecmp after held write");
		end_test("back-pressure");

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: all.f
common/bus_pkg.sv
common/clint_pkg.sv
clint/clint_bus_bridge.sv
clint/mtime_registers.sv
verilog/clint_timer_top.sv
tests/clint_timer_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= clint_timer_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
